// ==== hdl/immu_pkg.sv ====
package immu_pkg;

    // Sv32 field widths
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = 20;
    localparam int PPN_W         = 22;

    // Address and page number types
    typedef logic [31:0]        vaddr_t;
    typedef logic [33:0]        paddr_t;
    typedef logic [VPN_W-1:0]   vpn_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [31:0]        pte_t;

    // PTE permission bits
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;

    // PPN sits above the RSW field
    localparam int PTE_PPN_LSB = 10;

    // Walker FSM
    typedef enum logic [2:0] {
        idle,
        read_l1,
        wait_l1,
        read_l0,
        wait_l0,
        done
    } ptw_state_t;

    // Physical page number of an entry
    function automatic ppn_t pte_ppn(input pte_t pte);
        return pte[PTE_PPN_LSB +: PPN_W];
    endfunction

    // Leaf when readable or executable
    function automatic logic pte_is_leaf(input pte_t pte);
        return pte[PTE_R] | pte[PTE_X];
    endfunction

endpackage

// ==== hdl/itlb.sv ====
`timescale 1ns/1ps

module itlb import immu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic clk,
    input  logic rst_n,
    // Lookup side
    input  logic lookup,
    input  vpn_t lookup_vpn,
    // Invalidate everything
    input  logic flush,
    // Refill from the walker
    input  logic update,
    input  vpn_t update_vpn,
    input  ppn_t update_ppn,
    input  logic update_page_4m,
    // Lookup result in the same cycle
    output logic hit,
    output ppn_t hit_ppn,
    output logic hit_page_4m
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // Entry fields with one slot per index
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [9:0]             vpn_1_q   [TLB_ENTRIES];
    logic [9:0]             vpn_0_q   [TLB_ENTRIES];
    ppn_t                   ppn_q     [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] page_4m_q;

    logic [IDX_W-1:0] r_index;
    logic [IDX_W-1:0] w_index;
    logic             tag_match;
    logic             off_match;

    // Index from the low bits of vpn_1
    assign r_index = lookup_vpn[10 +: IDX_W];
    assign w_index = update_vpn[10 +: IDX_W];

    assign tag_match = valid_q[r_index] && (vpn_1_q[r_index] == lookup_vpn[19:10]);
    // Superpage entries ignore vpn_0
    assign off_match = page_4m_q[r_index] || (vpn_0_q[r_index] == lookup_vpn[9:0]);

    assign hit         = lookup && tag_match && off_match;
    assign hit_ppn     = ppn_q[r_index];
    assign hit_page_4m = page_4m_q[r_index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= '0;
            page_4m_q <= '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                vpn_1_q[i] <= '0;
                vpn_0_q[i] <= '0;
                ppn_q[i]   <= '0;
            end
        end else if (flush) begin
            // Flush wins over a refill in the same cycle
            valid_q <= '0;
        end else if (update) begin
            valid_q[w_index]   <= 1'b1;
            vpn_1_q[w_index]   <= update_vpn[19:10];
            vpn_0_q[w_index]   <= update_vpn[9:0];
            ppn_q[w_index]     <= update_ppn;
            page_4m_q[w_index] <= update_page_4m;
        end
    end

    // Refill and lookup never share a cycle
    a_no_refill_on_lookup: assert property (@(posedge clk) disable iff (!rst_n)
        update |-> !lookup);

endmodule

// ==== hdl/ptw.sv ====
`timescale 1ns/1ps

module ptw import immu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  ppn_t   satp_ppn,
    // Walk request from the front end
    input  logic   walk_start,
    input  vpn_t   walk_vpn,
    // Memory read port
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_rvalid,
    input  pte_t   mem_rdata,
    // Walk result
    output logic   walk_done,
    output logic   walk_fault,
    output ppn_t   walk_ppn,
    output logic   walk_page_4m,
    // TLB refill
    output logic   tlb_update,
    output vpn_t   tlb_vpn,
    output ppn_t   tlb_ppn,
    output logic   tlb_page_4m
);

    ptw_state_t state;
    ptw_state_t state_next;

    // Latched request and next table base
    vpn_t vpn_q;
    ppn_t base_ppn_q;

    ppn_t rdata_ppn;
    logic pte_bad;
    logic pte_leaf;
    logic misaligned;
    logic rsp_l1;
    logic rsp_l0;
    logic l1_finish;
    logic l1_fault;
    logic l0_fault;

    // PTE decode
    assign rdata_ppn  = pte_ppn(mem_rdata);
    assign pte_leaf   = pte_is_leaf(mem_rdata);
    // Invalid, or write without read
    assign pte_bad    = !mem_rdata[PTE_V] || (!mem_rdata[PTE_R] && mem_rdata[PTE_W]);
    // Superpage must be 4 MiB aligned
    assign misaligned = |rdata_ppn[9:0];

    assign rsp_l1 = (state == wait_l1) && mem_rvalid;
    assign rsp_l0 = (state == wait_l0) && mem_rvalid;

    // Level 1 ends on a fault or a superpage leaf
    assign l1_finish = rsp_l1 && (pte_bad || pte_leaf);
    assign l1_fault  = pte_bad || (pte_leaf && (!mem_rdata[PTE_X] || misaligned));
    // Level 0 must be an executable leaf
    assign l0_fault  = pte_bad || !pte_leaf || !mem_rdata[PTE_X];

    // Result leaves in the cycle of the last read return
    assign walk_done    = l1_finish || rsp_l0;
    assign walk_fault   = rsp_l0 ? l0_fault : l1_fault;
    assign walk_ppn     = walk_fault ? '0 : rdata_ppn;
    assign walk_page_4m = rsp_l1;

    // Refill only on success
    assign tlb_update  = walk_done && !walk_fault;
    assign tlb_vpn     = vpn_q;
    assign tlb_ppn     = rdata_ppn;
    assign tlb_page_4m = rsp_l1;

    // One read per level
    assign mem_req  = (state == read_l1) || (state == read_l0);
    assign mem_addr = {base_ppn_q, (state == read_l0) ? vpn_q[9:0] : vpn_q[19:10], 2'b00};

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (walk_start) begin
                    state_next = read_l1;
                end
            end
            read_l1: state_next = wait_l1;
            wait_l1: begin
                if (l1_finish) begin
                    state_next = done;
                end else if (mem_rvalid) begin
                    // Pointer to the next table
                    state_next = read_l0;
                end
            end
            read_l0: state_next = wait_l0;
            wait_l0: begin
                if (mem_rvalid) begin
                    state_next = done;
                end
            end
            done:    state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && walk_start) begin
            vpn_q      <= walk_vpn;
            base_ppn_q <= satp_ppn;
        end else if (rsp_l1 && !l1_finish) begin
            base_ppn_q <= rdata_ppn;
        end
    end

    // Memory returns only while a read is outstanding
    a_rvalid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rvalid |-> (state == wait_l1 || state == wait_l0));

    // Front end never starts a second walk
    a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        walk_start |-> (state == idle));

endmodule

// ==== hdl/immu_ctrl.sv ====
`timescale 1ns/1ps

module immu_ctrl import immu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // Fetch request
    input  logic   req,
    input  vaddr_t vaddr,
    // TLB lookup
    output logic   lookup,
    output vpn_t   lookup_vpn,
    input  logic   tlb_hit,
    input  ppn_t   tlb_ppn,
    input  logic   tlb_page_4m,
    // Walker handoff
    output logic   walk_start,
    output vpn_t   walk_vpn,
    input  logic   walk_done,
    input  logic   walk_fault,
    input  ppn_t   walk_ppn,
    input  logic   walk_page_4m,
    // Response to fetch
    output logic   resp_valid,
    output paddr_t paddr,
    output logic   fault,
    output logic   busy
);

    // Accepted request
    logic   pending_q;
    vaddr_t vaddr_q;

    // Build paddr from a ppn, superpages keep vpn_0
    function automatic paddr_t form_paddr(input ppn_t ppn, input logic page_4m,
                                          input vaddr_t va);
        if (page_4m) begin
            return {ppn[21:10], va[21:PAGE_OFFSET_W], va[PAGE_OFFSET_W-1:0]};
        end
        return {ppn, va[PAGE_OFFSET_W-1:0]};
    endfunction

    // Lookup in the cycle after acceptance
    assign lookup     = pending_q;
    assign lookup_vpn = vaddr_q[31:PAGE_OFFSET_W];

    // Miss goes straight to the walker
    assign walk_start = pending_q && !tlb_hit;
    assign walk_vpn   = lookup_vpn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q  <= 1'b0;
            resp_valid <= 1'b0;
            busy       <= 1'b0;
        end else begin
            pending_q  <= req;
            resp_valid <= (pending_q && tlb_hit) || walk_done;
            if (walk_start) begin
                busy <= 1'b1;
            end else if (walk_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Address and result payload
    always_ff @(posedge clk) begin
        if (req) begin
            vaddr_q <= vaddr;
        end
        if (pending_q && tlb_hit) begin
            paddr <= form_paddr(tlb_ppn, tlb_page_4m, vaddr_q);
            fault <= 1'b0;
        end else if (walk_done) begin
            // Faulting walks return a zero address
            paddr <= walk_fault ? '0 : form_paddr(walk_ppn, walk_page_4m, vaddr_q);
            fault <= walk_fault;
        end
    end

    // One translation in flight at a time
    a_no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> !(busy || pending_q || resp_valid));

endmodule

// ==== hdl/immu_top.sv ====
`timescale 1ns/1ps

module immu_top import immu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    // Fetch request
    input  logic   req,
    input  vaddr_t vaddr,
    // Control
    input  logic   flush,
    input  ppn_t   satp_ppn,
    output logic   busy,
    // Response
    output logic   resp_valid,
    output paddr_t paddr,
    output logic   fault,
    // Memory read port
    output logic   mem_req,
    output paddr_t mem_addr,
    input  logic   mem_rvalid,
    input  pte_t   mem_rdata
);

    // Front end to TLB
    logic lookup;
    vpn_t lookup_vpn;
    logic tlb_hit;
    ppn_t tlb_ppn;
    logic tlb_page_4m;

    // Front end to walker
    logic walk_start;
    vpn_t walk_vpn;
    logic walk_done;
    logic walk_fault;
    ppn_t walk_ppn;
    logic walk_page_4m;

    // Walker refill into the TLB
    logic tlb_update;
    vpn_t tlb_vpn;
    ppn_t tlb_upd_ppn;
    logic tlb_upd_page_4m;

    immu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .vaddr        (vaddr),
        .lookup       (lookup),
        .lookup_vpn   (lookup_vpn),
        .tlb_hit      (tlb_hit),
        .tlb_ppn      (tlb_ppn),
        .tlb_page_4m  (tlb_page_4m),
        .walk_start   (walk_start),
        .walk_vpn     (walk_vpn),
        .walk_done    (walk_done),
        .walk_fault   (walk_fault),
        .walk_ppn     (walk_ppn),
        .walk_page_4m (walk_page_4m),
        .resp_valid   (resp_valid),
        .paddr        (paddr),
        .fault        (fault),
        .busy         (busy)
    );

    itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_itlb (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup         (lookup),
        .lookup_vpn     (lookup_vpn),
        .flush          (flush),
        .update         (tlb_update),
        .update_vpn     (tlb_vpn),
        .update_ppn     (tlb_upd_ppn),
        .update_page_4m (tlb_upd_page_4m),
        .hit            (tlb_hit),
        .hit_ppn        (tlb_ppn),
        .hit_page_4m    (tlb_page_4m)
    );

    ptw u_ptw (
        .clk          (clk),
        .rst_n        (rst_n),
        .satp_ppn     (satp_ppn),
        .walk_start   (walk_start),
        .walk_vpn     (walk_vpn),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .walk_done    (walk_done),
        .walk_fault   (walk_fault),
        .walk_ppn     (walk_ppn),
        .walk_page_4m (walk_page_4m),
        .tlb_update   (tlb_update),
        .tlb_vpn      (tlb_vpn),
        .tlb_ppn      (tlb_upd_ppn),
        .tlb_page_4m  (tlb_upd_page_4m)
    );

endmodule

// ==== test/immu_checker.sv ====
`timescale 1ns/1ps

module immu_checker import immu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    // Request side
    input  logic   req,
    input  vaddr_t vaddr,
    input  logic   flush,
    input  ppn_t   satp_ppn,
    // DUT outputs
    input  logic   busy,
    input  logic   resp_valid,
    input  paddr_t paddr,
    input  logic   fault,
    input  logic   mem_req,
    input  paddr_t mem_addr,
    // Page table image held by the testbench
    input  pte_t   pt_mem [4096],
    output int     error_count,
    output int     resp_count
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // Shadow TLB
    logic sh_valid [TLB_ENTRIES];
    vpn_t sh_vpn   [TLB_ENTRIES];
    logic sh_4m    [TLB_ENTRIES];

    // Translation in flight
    logic   active;
    vaddr_t cur_va;
    paddr_t exp_pa;
    logic   exp_flt;
    logic   exp_4m;
    int     exp_lv;
    paddr_t exp_a1;
    paddr_t exp_a0;
    logic   pred_hit;
    int     walks;
    longint cycle;
    longint req_cycle;
    logic   reset_seen;

    // Only the low 16 KiB is backed and the rest reads as zero
    function automatic pte_t mem_word(input paddr_t addr);
        if (addr[33:14] != '0) begin
            return '0;
        end
        return pt_mem[addr[13:2]];
    endfunction

    // Sv32 walk over the page table image
    function automatic void ref_walk(input vaddr_t va, output paddr_t pa, output logic flt,
                                     output logic sp, output int lv,
                                     output paddr_t a1, output paddr_t a0);
        pte_t pte;
        ppn_t ppn;
        pa  = '0;
        flt = 1'b1;
        sp  = 1'b0;
        lv  = 1;
        a0  = '0;
        a1  = {satp_ppn, va[31:22], 2'b00};
        pte = mem_word(a1);
        ppn = pte[31:10];
        // Invalid, or W without R
        if (!pte[0] || (!pte[1] && pte[2])) begin
            return;
        end
        if (pte[1] || pte[3]) begin
            // Superpage leaf needs X and 4 MiB alignment
            if (pte[3] && ppn[9:0] == 10'd0) begin
                flt = 1'b0;
                sp  = 1'b1;
                pa  = {ppn[21:10], va[21:0]};
            end
            return;
        end
        lv  = 2;
        a0  = {ppn, va[21:12], 2'b00};
        pte = mem_word(a0);
        ppn = pte[31:10];
        // Level 0 must be a valid executable leaf
        if (pte[0] && !(!pte[1] && pte[2]) && pte[3]) begin
            flt = 1'b0;
            pa  = {ppn, va[11:0]};
        end
    endfunction

    function automatic logic shadow_hit(input vpn_t vpn);
        logic [IDX_W-1:0] idx;
        idx = vpn[10 +: IDX_W];
        return sh_valid[idx] && (sh_vpn[idx][19:10] == vpn[19:10])
            && (sh_4m[idx] || (sh_vpn[idx][9:0] == vpn[9:0]));
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                sh_valid[i] = 1'b0;
                sh_vpn[i]   = '0;
                sh_4m[i]    = 1'b0;
            end
            active      = 1'b0;
            reset_seen  = 1'b0;
            cycle       = 0;
            error_count = 0;
            resp_count  = 0;
        end else begin
            cycle++;
            // First cycle out of reset
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (resp_valid || busy || mem_req) begin
                    error_count++;
                    $display("outputs not idle right after reset at %0t", $time);
                end
            end
            if (flush) begin
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    sh_valid[i] = 1'b0;
                end
            end
            if (mem_req) begin
                walks++;
                if (!active || pred_hit || walks > exp_lv) begin
                    error_count++;
                    $display("unexpected page table read at %0t, address %h", $time, mem_addr);
                end else if (mem_addr !== ((walks == 1) ? exp_a1 : exp_a0)) begin
                    error_count++;
                    $display("mismatch at %0t: mem_addr got %h expected %h", $time, mem_addr,
                             (walks == 1) ? exp_a1 : exp_a0);
                end
                if (!busy) begin
                    error_count++;
                    $display("busy low during a page walk at %0t", $time);
                end
            end
            if (resp_valid) begin
                if (!active) begin
                    error_count++;
                    $display("response without a request at %0t", $time);
                end else begin
                    resp_count++;
                    if (paddr !== exp_pa) begin
                        error_count++;
                        $display("mismatch at %0t: paddr got %h expected %h (va %h)", $time,
                                 paddr, exp_pa, cur_va);
                    end
                    if (fault !== exp_flt) begin
                        error_count++;
                        $display("mismatch at %0t: fault got %b expected %b (va %h)", $time,
                                 fault, exp_flt, cur_va);
                    end
                    if (busy) begin
                        error_count++;
                        $display("busy still high with the response at %0t", $time);
                    end
                    if (pred_hit) begin
                        if (walks != 0 || cycle - req_cycle != 2) begin
                            error_count++;
                            $display("hit for va %h took %0d cycles and %0d reads at %0t",
                                     cur_va, cycle - req_cycle, walks, $time);
                        end
                    end else begin
                        if (walks != exp_lv) begin
                            error_count++;
                            $display("mismatch at %0t: walk reads got %0d expected %0d", $time,
                                     walks, exp_lv);
                        end
                        // Refill on success only
                        if (!exp_flt) begin
                            sh_valid[cur_va[22 +: IDX_W]] = 1'b1;
                            sh_vpn[cur_va[22 +: IDX_W]]   = cur_va[31:12];
                            sh_4m[cur_va[22 +: IDX_W]]    = exp_4m;
                        end
                    end
                    active = 1'b0;
                end
            end
            if (req) begin
                cur_va    = vaddr;
                pred_hit  = shadow_hit(vaddr[31:12]);
                ref_walk(vaddr, exp_pa, exp_flt, exp_4m, exp_lv, exp_a1, exp_a0);
                walks     = 0;
                req_cycle = cycle;
                active    = 1'b1;
            end
        end
    end

endmodule

// ==== test/immu_tb.sv ====
`timescale 1ns/1ps

module immu_tb import immu_pkg::*; ();

    localparam int     TLB_ENTRIES = 4;
    localparam int     CLK_PERIOD  = 20;
    localparam int     NUM_REQ     = 330;
    localparam longint WATCHDOG_NS = longint'(NUM_REQ * 20 + 200) * CLK_PERIOD;

    // PTE flag sets
    localparam logic [3:0] XRV = 4'b1011;
    localparam logic [3:0] XV  = 4'b1001;
    localparam logic [3:0] RV  = 4'b0011;
    localparam logic [3:0] WV  = 4'b0101;
    localparam logic [3:0] V   = 4'b0001;

    logic   clk;
    logic   rst_n;
    logic   req;
    vaddr_t vaddr;
    logic   flush;
    ppn_t   satp_ppn;
    logic   busy;
    logic   resp_valid;
    paddr_t paddr;
    logic   fault;
    logic   mem_req;
    paddr_t mem_addr;
    logic   mem_rvalid;
    pte_t   mem_rdata;

    // Page tables, 16 KiB of backed memory
    pte_t        pt_mem [4096];
    logic [31:0] stim_rng;
    logic [31:0] mem_rng;
    paddr_t      pend_addr;
    int          wait_cnt;
    int          issued;
    int          chk_errors;
    int          chk_resps;
    vpn_t        pool [12];

    immu_top #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .vaddr      (vaddr),
        .flush      (flush),
        .satp_ppn   (satp_ppn),
        .busy       (busy),
        .resp_valid (resp_valid),
        .paddr      (paddr),
        .fault      (fault),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    immu_checker #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .vaddr       (vaddr),
        .flush       (flush),
        .satp_ppn    (satp_ppn),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .paddr       (paddr),
        .fault       (fault),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .pt_mem      (pt_mem),
        .error_count (chk_errors),
        .resp_count  (chk_resps)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pte_t make_pte(input ppn_t ppn, input logic [3:0] flags);
        return {ppn, 6'b000000, flags};
    endfunction

    task automatic set_pte(input ppn_t table_ppn, input logic [9:0] idx, input pte_t pte);
        paddr_t addr;
        addr = {table_ppn, idx, 2'b00};
        pt_mem[addr[13:2]] = pte;
    endtask

    task automatic build_page_table();
        for (int i = 0; i < 4096; i++) begin
            pt_mem[i] = '0;
        end
        // Root at ppn 1, index 2 stays invalid
        set_pte(22'd1, 10'd0, make_pte(22'd2, V));
        set_pte(22'd1, 10'd1, make_pte(22'h00400, XRV));
        set_pte(22'd1, 10'd3, make_pte(22'h00500, WV));
        set_pte(22'd1, 10'd4, make_pte(22'd3, V));
        set_pte(22'd1, 10'd5, make_pte(22'h00800, RV));
        // Misaligned superpage
        set_pte(22'd1, 10'd6, make_pte(22'h00801, XRV));
        set_pte(22'd1, 10'd9, make_pte(22'h00C00, XV));
        // Level 0 tables at ppn 2 and 3
        set_pte(22'd2, 10'd0, make_pte(22'h12345, XRV));
        set_pte(22'd2, 10'd1, make_pte(22'h00077, XV));
        set_pte(22'd2, 10'd2, make_pte(22'h00009, V));
        set_pte(22'd2, 10'd3, make_pte(22'h00009, WV));
        set_pte(22'd2, 10'd4, make_pte(22'h00055, RV));
        set_pte(22'd3, 10'd0, make_pte(22'h3ABCD, XRV));
        set_pte(22'd3, 10'd5, make_pte(22'h00100, XV));
    endtask

    // One request, then wait for its response
    task automatic translate(input vaddr_t va);
        @(negedge clk);
        req   = 1'b1;
        vaddr = va;
        @(negedge clk);
        req = 1'b0;
        while (!resp_valid) begin
            @(negedge clk);
        end
        issued++;
    endtask

    task automatic flush_tlb();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Memory answers 1 to 4 cycles after each read
    always @(negedge clk) begin
        mem_rvalid = 1'b0;
        if (!rst_n) begin
            wait_cnt = 0;
        end else if (wait_cnt != 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = (pend_addr[33:14] != '0) ? '0 : pt_mem[pend_addr[13:2]];
            end
        end else if (mem_req) begin
            pend_addr = mem_addr;
            mem_rng   = xorshift32(mem_rng);
            wait_cnt  = int'(mem_rng[1:0]) + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the DUT stopped answering after %0d requests", issued);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        req        = 1'b0;
        vaddr      = '0;
        flush      = 1'b0;
        satp_ppn   = 22'd1;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        wait_cnt   = 0;
        issued     = 0;
        stim_rng   = 32'd41;
        mem_rng    = xorshift32(32'd41);
        pool = '{20'h00000, 20'h00001, 20'h00002, 20'h00004, 20'h00400, 20'h00403,
                 20'h01000, 20'h01005, 20'h02400, 20'h02401, 20'h00800, 20'h01C00};
        build_page_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // 4 KiB page, then a hit
        translate(32'h0000_0123);
        translate(32'h0000_0456);
        // Superpage and a second address inside it
        translate(32'h0040_1ABC);
        translate(32'h0057_F010);
        // Each fault twice, the retry walks again
        translate(32'h0080_0000);
        translate(32'h0080_0000);
        translate(32'h00C0_0000);
        translate(32'h00C0_0000);
        translate(32'h0140_0000);
        translate(32'h0140_0000);
        translate(32'h0180_0000);
        translate(32'h0180_0000);
        translate(32'h0000_2000);
        translate(32'h0000_2000);
        translate(32'h0000_3000);
        translate(32'h0000_3000);
        translate(32'h0000_4000);
        translate(32'h0000_4000);
        translate(32'h0000_1010);
        translate(32'h0000_1FFC);
        // vpn_1 4 and 0 share index 0, 9 and 1 share index 1
        translate(32'h0100_0040);
        translate(32'h0000_0200);
        translate(32'h0100_0080);
        translate(32'h0240_0010);
        translate(32'h0040_0010);
        // Cached pages walk again after flush
        translate(32'h0000_0300);
        translate(32'h0040_0020);
        flush_tlb();
        translate(32'h0000_0300);
        translate(32'h0040_0020);
        translate(32'h0100_5000);

        // Random mix with occasional flushes
        for (int n = 0; n < 300; n++) begin
            stim_rng = xorshift32(stim_rng);
            if (stim_rng[31:27] == 5'd0) begin
                flush_tlb();
            end
            translate({pool[int'(stim_rng[7:4]) % 12], stim_rng[27:16]});
        end

        repeat (5) @(negedge clk);
        $display("requests %0d, responses %0d, errors %0d", issued, chk_resps, chk_errors);
        if (chk_errors == 0 && chk_resps == issued) begin
            $display("Simulation passed");
        end else begin
            if (chk_resps != issued) begin
                $display("response count does not match the number of requests");
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/immu_pkg.sv
hdl/itlb.sv
hdl/ptw.sv
hdl/immu_ctrl.sv
hdl/immu_top.sv
test/immu_checker.sv
test/immu_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction MMU

TOP = immu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

obj_dir/V$(TOP): flist.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

# Pass only when the pass line shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
